//--- include/mem_consts.svh
`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

// words moved by one engine transfer
`define BLOCK_WORDS 8

// cycles between the command word and the first load word
`define EXT_LATENCY 2

`define DATA_DEPTH 1024   // data bank words
`define INSTR_LINES 512   // instruction bank lines, 64 bits each

`endif

//--- hdl/memTypes.sv
package memTypes;

    typedef logic [31:0] word_t;
    typedef logic [3:0] wmask_t;       // one bit per byte, 1 writes
    typedef logic [9:0] sramAddr_t;    // word index inside a bank
    typedef logic [29:0] extAddr_t;    // external word address
    typedef logic [9:0] progress_t;    // words done in the current transfer

    // instruction side
    typedef logic [7:0] fetchAddr_t;   // 128-bit group index
    typedef logic [127:0] fetch_t;

    // transfer engine
    typedef enum logic [2:0] {
        IDLE,
        COMMAND,   // command word on the external bus
        WAIT,      // load latency
        STREAM,
        DONE
    } engineState_t;

endpackage

//--- hdl/cacheBus.sv
// engine side access to one SRAM bank
interface cacheBus;

    logic own;                  // engine holds the bank
    logic we;
    memTypes::wmask_t wm;
    memTypes::sramAddr_t addr;
    memTypes::word_t data;
    memTypes::word_t rdata;     // one cycle after addr

    modport engine (
        output own,
        output we,
        output wm,
        output addr,
        output data,
        input rdata
    );

    modport bank (
        input own,
        input we,
        input wm,
        input addr,
        input data,
        output rdata
    );

endinterface

//--- hdl/dataCacheBank.sv
`include "mem_consts.svh"

module dataCacheBank (
    input logic SPI_clk,
    input logic reset,
    cacheBus.bank bus,
    input logic coreWe,
    input memTypes::wmask_t coreWm,
    input memTypes::sramAddr_t coreWaddr,
    input memTypes::word_t coreWdata,
    input logic coreRe,
    input memTypes::sramAddr_t coreRaddr,
    output memTypes::word_t coreRdata
);

    localparam int BYTES = $bits(memTypes::wmask_t);

    memTypes::word_t mem [0:`DATA_DEPTH-1];

    // port 0, shared between engine and core writes
    logic p0We;
    memTypes::wmask_t p0Wm;
    memTypes::sramAddr_t p0Addr;
    memTypes::word_t p0Data;

    always_comb begin
        if (bus.own) begin
            p0We = bus.we;
            p0Wm = bus.wm;
            p0Addr = bus.addr;
            p0Data = bus.data;
        end else begin
            p0We = coreWe;
            p0Wm = coreWm;
            p0Addr = coreWaddr;
            p0Data = coreWdata;
        end
    end

    always_ff @(posedge SPI_clk) begin
        if (p0We && !reset) begin
            for (int b = 0; b < BYTES; b++) begin
                if (p0Wm[b]) begin
                    mem[p0Addr][8*b +: 8] <= p0Data[8*b +: 8];
                end
            end
        end
        // read before write on the same address
        if (bus.own) begin
            bus.rdata <= mem[p0Addr];
        end
    end

    // port 1, core reads only
    always_ff @(posedge SPI_clk) begin
        if (coreRe && !bus.own) begin
            coreRdata <= mem[coreRaddr];
        end
    end

endmodule

//--- hdl/instrCacheBank.sv
`include "mem_consts.svh"

module instrCacheBank (
    input logic SPI_clk,
    input logic reset,
    cacheBus.bank bus,
    input logic fetchEn,
    input memTypes::fetchAddr_t fetchAddr,
    output memTypes::fetch_t fetchData
);

    localparam int LINE_BITS = $clog2(`INSTR_LINES);
    localparam int BYTES = $bits(memTypes::wmask_t);

    typedef logic [63:0] line_t;

    line_t mem [0:`INSTR_LINES-1];

    // engine word lands in one half of a line
    logic [LINE_BITS-1:0] engLine;
    logic engHigh;
    logic [5:0] halfBase;     // bit offset of the selected half

    assign engLine = bus.addr[9:1];
    assign engHigh = bus.addr[0];
    assign halfBase = {engHigh, 5'd0};

    // fetch reads both lines of a group
    logic [LINE_BITS-1:0] fetchLo;
    logic [LINE_BITS-1:0] fetchHi;

    assign fetchLo = {fetchAddr, 1'b0};
    assign fetchHi = {fetchAddr, 1'b1};

    always_ff @(posedge SPI_clk) begin
        if (bus.own && bus.we && !reset) begin
            for (int b = 0; b < BYTES; b++) begin
                if (bus.wm[b]) begin
                    mem[engLine][halfBase + 8*b +: 8] <= bus.data[8*b +: 8];
                end
            end
        end
        if (bus.own) begin
            bus.rdata <= mem[engLine][halfBase +: 32];
        end
    end

    always_ff @(posedge SPI_clk) begin
        if (fetchEn && !bus.own) begin
            fetchData <= {mem[fetchHi], mem[fetchLo]};   // word j at bits 32j
        end
    end

endmodule

//--- hdl/transferEngine.sv
`include "mem_consts.svh"

module transferEngine (
    input logic SPI_clk,
    input logic reset,
    input logic mcCe,
    input logic mcWe,
    input logic mcCacheId,
    input memTypes::sramAddr_t mcSramAddr,
    input memTypes::extAddr_t mcExtAddr,
    output memTypes::progress_t mcProgress,
    output logic mcBusy,
    cacheBus.engine dataBus,
    cacheBus.engine instrBus,
    output logic extEn,
    output logic extOen,
    output memTypes::word_t extBusOut,
    input memTypes::word_t extBusIn
);

    localparam memTypes::progress_t LAST_WORD = memTypes::progress_t'(`BLOCK_WORDS - 1);
    localparam memTypes::progress_t LAST_WAIT = memTypes::progress_t'(`EXT_LATENCY - 1);

    memTypes::engineState_t state;
    memTypes::progress_t cnt;       // wait cycles, then words
    memTypes::progress_t progress;

    logic isStore;
    logic cacheId;                  // 1 selects the instruction bank
    logic weReg;
    memTypes::word_t cmdWord;
    memTypes::word_t wdata;
    memTypes::sramAddr_t busAddr;
    memTypes::word_t rdSel;

    always_ff @(posedge SPI_clk) begin
        if (reset) begin
            state <= memTypes::IDLE;
            cnt <= '0;
            progress <= '0;
            extOen <= 1'b0;
            weReg <= 1'b0;
        end else begin
            case (state)
                memTypes::IDLE: begin
                    if (mcCe) begin
                        state <= memTypes::COMMAND;
                        progress <= '0;
                    end
                end
                memTypes::COMMAND: begin
                    cnt <= '0;
                    state <= isStore ? memTypes::STREAM : memTypes::WAIT;
                end
                memTypes::WAIT: begin
                    if (cnt == LAST_WAIT) begin
                        cnt <= '0;
                        state <= memTypes::STREAM;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                memTypes::STREAM: begin
                    if (cnt == LAST_WORD) state <= memTypes::DONE;
                    else cnt <= cnt + 1'b1;
                end
                memTypes::DONE: state <= memTypes::IDLE;   // last word in flight
                default: state <= memTypes::IDLE;
            endcase

            // bank read data reaches the bus one cycle late
            extOen <= isStore && (state == memTypes::STREAM);
            weReg <= !isStore && (state == memTypes::STREAM);

            if (weReg || extOen) begin
                progress <= progress + 1'b1;
            end
        end
    end

    // command and payload, no reset
    always_ff @(posedge SPI_clk) begin
        if (state == memTypes::IDLE && mcCe) begin
            isStore <= mcWe;
            cacheId <= mcCacheId;
            cmdWord <= {mcWe, 1'b0, mcExtAddr};
            busAddr <= mcSramAddr;
        end else if ((isStore && state == memTypes::STREAM) || weReg) begin
            busAddr <= busAddr + 1'b1;
        end
        if (state == memTypes::STREAM) begin
            wdata <= extBusIn;
        end
    end

    assign mcBusy = (state != memTypes::IDLE);
    assign mcProgress = progress;
    assign extEn = (state == memTypes::COMMAND);

    assign rdSel = cacheId ? instrBus.rdata : dataBus.rdata;
    assign extBusOut = extOen ? rdSel : cmdWord;

    // both buses see the same address and data, own picks the bank
    assign dataBus.own = mcBusy && !cacheId;
    assign dataBus.we = weReg && !cacheId;
    assign dataBus.wm = '1;
    assign dataBus.addr = busAddr;
    assign dataBus.data = wdata;

    assign instrBus.own = mcBusy && cacheId;
    assign instrBus.we = weReg && cacheId;
    assign instrBus.wm = '1;
    assign instrBus.addr = busAddr;
    assign instrBus.data = wdata;

endmodule

//--- hdl/memSubsystem.sv
module memSubsystem (
    input logic SPI_clk,
    input logic reset,

    // transfer engine commands
    input logic mcCe,
    input logic mcWe,
    input logic mcCacheId,
    input memTypes::sramAddr_t mcSramAddr,
    input memTypes::extAddr_t mcExtAddr,
    output memTypes::progress_t mcProgress,
    output logic mcBusy,

    // external memory
    output logic extEn,
    output logic extOen,
    output memTypes::word_t extBusOut,
    input memTypes::word_t extBusIn,

    // core data port
    input logic dWe,
    input memTypes::wmask_t dWm,
    input memTypes::sramAddr_t dWaddr,
    input memTypes::word_t dWdata,
    input logic dRe,
    input memTypes::sramAddr_t dRaddr,
    output memTypes::word_t dRdata,

    // core fetch port
    input logic iFetchEn,
    input memTypes::fetchAddr_t iFetchAddr,
    output memTypes::fetch_t iFetchData
);

    cacheBus dataBus();
    cacheBus instrBus();

    transferEngine u_engine (
        .SPI_clk(SPI_clk),
        .reset(reset),
        .mcCe(mcCe),
        .mcWe(mcWe),
        .mcCacheId(mcCacheId),
        .mcSramAddr(mcSramAddr),
        .mcExtAddr(mcExtAddr),
        .mcProgress(mcProgress),
        .mcBusy(mcBusy),
        .dataBus(dataBus),
        .instrBus(instrBus),
        .extEn(extEn),
        .extOen(extOen),
        .extBusOut(extBusOut),
        .extBusIn(extBusIn)
    );

    dataCacheBank u_dataBank (
        .SPI_clk(SPI_clk),
        .reset(reset),
        .bus(dataBus),
        .coreWe(dWe),
        .coreWm(dWm),
        .coreWaddr(dWaddr),
        .coreWdata(dWdata),
        .coreRe(dRe),
        .coreRaddr(dRaddr),
        .coreRdata(dRdata)
    );

    instrCacheBank u_instrBank (
        .SPI_clk(SPI_clk),
        .reset(reset),
        .bus(instrBus),
        .fetchEn(iFetchEn),
        .fetchAddr(iFetchAddr),
        .fetchData(iFetchData)
    );

endmodule

//--- testbench/memSubsystem_chk.sv
module memSubsystem_chk (
    input logic SPI_clk,
    input logic reset,
    input logic extEn,
    input logic extOen,
    input logic mcBusy,
    input logic dataOwn,
    input logic instrOwn
);

    int failures = 0;

    // command word is a single cycle strobe
    extEnPulse: assert property (@(posedge SPI_clk) disable iff (reset) extEn |=> !extEn)
        else begin
            failures++;
            $error("extEn stayed high for more than one cycle");
        end

    extOenBusy: assert property (@(posedge SPI_clk) disable iff (reset) extOen |-> mcBusy)
        else begin
            failures++;
            $error("extOen high while the engine is idle");
        end

    ownOneHot: assert property (@(posedge SPI_clk) disable iff (reset) !(dataOwn && instrOwn))
        else begin
            failures++;
            $error("engine owns both banks at once");
        end

endmodule

bind transferEngine memSubsystem_chk u_chk (
    .SPI_clk(SPI_clk),
    .reset(reset),
    .extEn(extEn),
    .extOen(extOen),
    .mcBusy(mcBusy),
    .dataOwn(dataBus.own),
    .instrOwn(instrBus.own)
);

//--- testbench/memScoreboard.sv
`include "mem_consts.svh"

module memScoreboard (
    input logic SPI_clk,
    input logic reset,
    input logic mcCe,
    input logic mcWe,
    input logic mcCacheId,
    input memTypes::sramAddr_t mcSramAddr,
    input memTypes::extAddr_t mcExtAddr,
    input memTypes::progress_t mcProgress,
    input logic mcBusy,
    input logic extEn,
    input logic extOen,
    input memTypes::word_t extBusOut,
    input logic dWe,
    input memTypes::wmask_t dWm,
    input memTypes::sramAddr_t dWaddr,
    input memTypes::word_t dWdata,
    input logic dRe,
    input memTypes::sramAddr_t dRaddr,
    input memTypes::word_t dRdata,
    input logic iFetchEn,
    input memTypes::fetchAddr_t iFetchAddr,
    input memTypes::fetch_t iFetchData
);

    memTypes::word_t dataMirror [0:`DATA_DEPTH-1];
    memTypes::word_t instrMirror [0:2*`INSTR_LINES-1];   // word view of the lines
    memTypes::word_t extMirror [0:4095];

    int errorCount = 0;
    int testsRun = 0;
    int testsFailed = 0;
    int errorsAtTestStart = 0;

    // transfer in progress
    logic active = 1'b0;
    logic curWe;
    logic curId;
    memTypes::sramAddr_t curSram;
    memTypes::extAddr_t curExt;
    int cycles;
    int enSeen;
    int outIdx;

    logic readPending = 1'b0;
    memTypes::word_t readExpect;
    memTypes::sramAddr_t readAddr;
    logic fetchPending = 1'b0;
    memTypes::fetch_t fetchExpect;
    logic prevReset = 1'b0;

    task automatic setExtWord(input int idx, input memTypes::word_t w);
        extMirror[idx] = w;
    endtask

    task automatic reportError(input string msg);
        $display("** Error at %0t: %s", $time, msg);
        errorCount++;
    endtask

    task automatic finishTest(input int idx, input string name);
        int fails;
        fails = errorCount - errorsAtTestStart;
        testsRun++;
        if (fails == 0) begin
            $display("test %0d %s: ok", idx, name);
        end else begin
            testsFailed++;
            $display("test %0d %s: %0d mismatches", idx, name, fails);
        end
        errorsAtTestStart = errorCount;
    endtask

    always @(posedge SPI_clk) begin
        memTypes::sramAddr_t idx;
        memTypes::word_t expWord;
        int limit;
        if (prevReset && !reset) begin
            if (mcBusy || extEn || extOen || mcProgress != 0) begin
                reportError("engine outputs not idle after reset");
            end
        end
        prevReset = reset;
        if (!reset) begin
            if (readPending) begin
                if (dRdata !== readExpect) begin
                    reportError($sformatf("data read %0d got %h expected %h",
                        readAddr, dRdata, readExpect));
                end
                readPending = 1'b0;
            end
            if (fetchPending) begin
                if (iFetchData !== fetchExpect) begin
                    reportError($sformatf("fetch got %h expected %h", iFetchData, fetchExpect));
                end
                fetchPending = 1'b0;
            end
            if (dRe) begin
                readExpect = dataMirror[dRaddr];   // read before write
                readAddr = dRaddr;
                readPending = 1'b1;
            end
            if (iFetchEn) begin
                for (int j = 0; j < 4; j++) begin
                    idx = memTypes::sramAddr_t'({iFetchAddr, 2'b00}) + 10'(j);
                    fetchExpect[32*j +: 32] = instrMirror[idx];
                end
                fetchPending = 1'b1;
            end
            if (dWe) begin
                for (int b = 0; b < 4; b++) begin
                    if (dWm[b]) dataMirror[dWaddr][8*b +: 8] = dWdata[8*b +: 8];
                end
            end
            if (active) begin
                cycles++;
                if (cycles == 1 && mcProgress != 0) begin
                    reportError($sformatf("mcProgress %0d at transfer start", mcProgress));
                end
                if (extEn) begin
                    enSeen++;
                    if (extBusOut !== {curWe, 1'b0, curExt}) begin
                        reportError($sformatf("command word %h expected %h",
                            extBusOut, {curWe, 1'b0, curExt}));
                    end
                end
                if (extOen) begin
                    idx = curSram + 10'(outIdx);
                    expWord = curId ? instrMirror[idx] : dataMirror[idx];
                    if (!curWe || extBusOut !== expWord) begin
                        reportError($sformatf("store word %0d got %h expected %h",
                            outIdx, extBusOut, expWord));
                    end
                    extMirror[12'(curExt + 30'(outIdx))] = expWord;
                    outIdx++;
                end
                if (!mcBusy) begin
                    limit = curWe ? `BLOCK_WORDS + 3 : `BLOCK_WORDS + `EXT_LATENCY + 3;
                    if (cycles > limit) begin
                        reportError($sformatf("mcBusy fell after %0d cycles, limit %0d",
                            cycles, limit));
                    end
                    if (mcProgress != `BLOCK_WORDS) begin
                        reportError($sformatf("mcProgress ended at %0d", mcProgress));
                    end
                    if (enSeen != 1) begin
                        reportError($sformatf("%0d command cycles in one transfer", enSeen));
                    end
                    if (curWe && outIdx != `BLOCK_WORDS) begin
                        reportError($sformatf("%0d words stored", outIdx));
                    end
                    active = 1'b0;
                end
            end else if (extEn || extOen) begin
                reportError("external bus active outside a transfer");
            end
            if (mcCe && !mcBusy) begin
                active = 1'b1;
                curWe = mcWe;
                curId = mcCacheId;
                curSram = mcSramAddr;
                curExt = mcExtAddr;
                cycles = 0;
                enSeen = 0;
                outIdx = 0;
                // a load fixes the bank contents right away
                if (!mcWe) begin
                    for (int i = 0; i < `BLOCK_WORDS; i++) begin
                        idx = mcSramAddr + 10'(i);
                        expWord = extMirror[12'(mcExtAddr + 30'(i))];
                        if (mcCacheId) instrMirror[idx] = expWord;
                        else dataMirror[idx] = expWord;
                    end
                end
            end
        end
    end

endmodule

//--- testbench/memSubsystemTb.sv
`include "mem_consts.svh"

module memSubsystemTb;

    localparam int EXT_WORDS = 4096;
    localparam int BUSY_LIMIT = 60;
    localparam int ROWS = 14;

    localparam int OP_LOAD = 0;
    localparam int OP_STORE = 1;
    localparam int OP_WRITE = 2;
    localparam int OP_READ = 3;
    localparam int OP_FETCH = 4;
    localparam int OP_LOAD_BUSY = 5;     // second mcCe while busy
    localparam int OP_READ_DURING = 6;   // data reads during an instruction load

    typedef struct {
        int kind;
        logic cacheId;
        memTypes::sramAddr_t sramAddr;
        memTypes::extAddr_t extAddr;
        memTypes::wmask_t mask;
        memTypes::word_t data;
        memTypes::sramAddr_t raddr;
    } stimRow_t;

    logic SPI_clk;
    logic reset;
    logic mcCe;
    logic mcWe;
    logic mcCacheId;
    memTypes::sramAddr_t mcSramAddr;
    memTypes::extAddr_t mcExtAddr;
    memTypes::progress_t mcProgress;
    logic mcBusy;
    logic extEn;
    logic extOen;
    memTypes::word_t extBusOut;
    memTypes::word_t extBusIn = '0;
    logic dWe;
    memTypes::wmask_t dWm;
    memTypes::sramAddr_t dWaddr;
    memTypes::word_t dWdata;
    logic dRe;
    memTypes::sramAddr_t dRaddr;
    memTypes::word_t dRdata;
    logic iFetchEn;
    memTypes::fetchAddr_t iFetchAddr;
    memTypes::fetch_t iFetchData;

    memTypes::word_t extMem [0:EXT_WORDS-1];
    stimRow_t stim [0:ROWS-1];
    int timeouts = 0;

    memSubsystem u_dut (.*);

    memScoreboard u_scoreboard (.*);

    initial begin
        SPI_clk = 1'b0;
        forever #10 SPI_clk = ~SPI_clk;
    end

    // external memory, loads come back EXT_LATENCY+1 cycles after the command
    logic loadOn = 1'b0;
    int sinceCmd = 0;
    int stIdx = 0;
    logic [11:0] ldBase;
    logic [11:0] stBase;

    always @(posedge SPI_clk) begin
        int wordIdx;
        extBusIn <= '0;
        if (reset) begin
            loadOn = 1'b0;
        end else begin
            if (extEn) begin
                if (extBusOut[31]) begin
                    stBase = extBusOut[11:0];
                    stIdx = 0;
                end else begin
                    ldBase = extBusOut[11:0];
                    loadOn = 1'b1;
                    sinceCmd = 1;
                end
            end else if (loadOn) begin
                sinceCmd++;
                wordIdx = sinceCmd - (`EXT_LATENCY + 1);
                if (wordIdx >= 0 && wordIdx < `BLOCK_WORDS) begin
                    extBusIn <= extMem[12'(ldBase + 12'(wordIdx))];
                end
                if (wordIdx >= `BLOCK_WORDS - 1) loadOn = 1'b0;
            end
            if (extOen) begin
                extMem[12'(stBase + 12'(stIdx))] = extBusOut;
                stIdx++;
            end
        end
    end

    function automatic string opName(input int kind);
        case (kind)
            OP_LOAD: return "load";
            OP_STORE: return "store";
            OP_WRITE: return "core write";
            OP_READ: return "core read";
            OP_FETCH: return "fetch";
            OP_LOAD_BUSY: return "load with extra mcCe";
            default: return "reads during load";
        endcase
    endfunction

    task automatic idleCycles(input int n);
        repeat (n) @(posedge SPI_clk);
    endtask

    task automatic startTransfer(input stimRow_t row, input logic isStore, input logic extraCe);
        @(posedge SPI_clk);
        mcCe <= 1'b1;
        mcWe <= isStore;
        mcCacheId <= row.cacheId;
        mcSramAddr <= row.sramAddr;
        mcExtAddr <= row.extAddr;
        @(posedge SPI_clk);
        mcCe <= extraCe;
        if (extraCe) begin
            mcExtAddr <= row.extAddr + 30'd64;   // must not start anything
            @(posedge SPI_clk);
            mcCe <= 1'b0;
        end
    endtask

    task automatic waitIdle(input string what);
        int n;
        n = 0;
        do begin
            @(posedge SPI_clk);
            n++;
        end while (mcBusy && n < BUSY_LIMIT);
        if (mcBusy) begin
            $display("timeout: mcBusy still high %0d cycles into the %s", n, what);
            timeouts++;
        end
    endtask

    task automatic readBlock(input memTypes::sramAddr_t addr);
        for (int i = 0; i < `BLOCK_WORDS; i++) begin
            @(posedge SPI_clk);
            dRe <= 1'b1;
            dRaddr <= addr + 10'(i);
        end
        @(posedge SPI_clk);
        dRe <= 1'b0;
    endtask

    initial begin
        int total;
        reset = 1'b1;
        mcCe = 1'b0;
        mcWe = 1'b0;
        mcCacheId = 1'b0;
        mcSramAddr = '0;
        mcExtAddr = '0;
        dWe = 1'b0;
        dWm = '0;
        dWaddr = '0;
        dWdata = '0;
        dRe = 1'b0;
        dRaddr = '0;
        iFetchEn = 1'b0;
        iFetchAddr = '0;

        void'($urandom(48));
        for (int i = 0; i < EXT_WORDS; i++) begin
            extMem[i] = $urandom;
            u_scoreboard.setExtWord(i, extMem[i]);
        end

        stim[0] = '{OP_LOAD, 1'b0, 10'd16, 30'd100, 4'h0, 32'h0, 10'd0};
        stim[1] = '{OP_READ, 1'b0, 10'd0, 30'd0, 4'h0, 32'h0, 10'd16};
        stim[2] = '{OP_WRITE, 1'b0, 10'd18, 30'd0, 4'b0101, 32'hA5A5_5A5A, 10'd0};
        stim[3] = '{OP_WRITE, 1'b0, 10'd21, 30'd0, 4'b1000, 32'h1234_5678, 10'd0};
        stim[4] = '{OP_STORE, 1'b0, 10'd16, 30'd2000, 4'h0, 32'h0, 10'd0};
        stim[5] = '{OP_LOAD, 1'b0, 10'd300, 30'd2000, 4'h0, 32'h0, 10'd0};   // read the store back
        stim[6] = '{OP_READ, 1'b0, 10'd0, 30'd0, 4'h0, 32'h0, 10'd300};
        stim[7] = '{OP_LOAD, 1'b1, 10'd40, 30'd300, 4'h0, 32'h0, 10'd0};
        stim[8] = '{OP_FETCH, 1'b0, 10'd0, 30'd0, 4'h0, 32'h0, 10'd10};
        stim[9] = '{OP_LOAD_BUSY, 1'b0, 10'd100, 30'd500, 4'h0, 32'h0, 10'd0};
        stim[10] = '{OP_READ, 1'b0, 10'd0, 30'd0, 4'h0, 32'h0, 10'd100};
        stim[11] = '{OP_STORE, 1'b1, 10'd40, 30'd3000, 4'h0, 32'h0, 10'd0};
        stim[12] = '{OP_READ_DURING, 1'b1, 10'd200, 30'd700, 4'h0, 32'h0, 10'd16};
        stim[13] = '{OP_FETCH, 1'b0, 10'd0, 30'd0, 4'h0, 32'h0, 10'd50};

        repeat (4) @(posedge SPI_clk);
        reset <= 1'b0;
        idleCycles(2);

        for (int r = 0; r < ROWS; r++) begin
            case (stim[r].kind)
                OP_LOAD, OP_STORE, OP_LOAD_BUSY: begin
                    startTransfer(stim[r], stim[r].kind == OP_STORE, stim[r].kind == OP_LOAD_BUSY);
                    waitIdle(opName(stim[r].kind));
                end
                OP_WRITE: begin
                    @(posedge SPI_clk);
                    dWe <= 1'b1;
                    dWm <= stim[r].mask;
                    dWaddr <= stim[r].sramAddr;
                    dWdata <= stim[r].data;
                    @(posedge SPI_clk);
                    dWe <= 1'b0;
                end
                OP_READ: readBlock(stim[r].raddr);
                OP_FETCH: begin
                    @(posedge SPI_clk);
                    iFetchEn <= 1'b1;
                    iFetchAddr <= stim[r].raddr[7:0];
                    @(posedge SPI_clk);
                    iFetchEn <= 1'b0;
                end
                default: begin
                    startTransfer(stim[r], 1'b0, 1'b0);
                    readBlock(stim[r].raddr);
                    waitIdle(opName(stim[r].kind));
                end
            endcase
            idleCycles(3);
            u_scoreboard.finishTest(r, opName(stim[r].kind));
        end

        total = u_scoreboard.errorCount + timeouts + u_dut.u_engine.u_chk.failures;
        $display("%0d tests, %0d failed, %0d mismatches, %0d timeouts, %0d assertion failures",
            u_scoreboard.testsRun, u_scoreboard.testsFailed, u_scoreboard.errorCount,
            timeouts, u_dut.u_engine.u_chk.failures);
        if (total == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- all.f
+incdir+include
hdl/memTypes.sv
hdl/cacheBus.sv
hdl/dataCacheBank.sv
hdl/instrCacheBank.sv
hdl/transferEngine.sv
hdl/memSubsystem.sv
testbench/memSubsystem_chk.sv
testbench/memScoreboard.sv
testbench/memSubsystemTb.sv

//--- Makefile
TOP ?= memSubsystemTb
FILELIST ?= all.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert -Wno-fatal
SIM_ARGS ?= +verilator+error+limit+100
FAIL_MSG ?= STATUS: FAIL
PASS_MSG ?= STATUS: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without a status line, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
